// ==== flist.f ====
hdl/fetch_pkg.sv
hdl/fetch_fifo.sv
hdl/prefetch_buffer.sv
hdl/instr_ram.sv
hdl/fetch_top.sv
testbench/tb_fetch_top.sv

// ==== Makefile ====
# fetch front end, verilator simulation

.PHONY: all run lint clean

all: run

obj_dir/Vtb_fetch_top: flist.f hdl/*.sv testbench/*.sv
	verilator --binary --timing --assert -f flist.f --top-module tb_fetch_top

run: obj_dir/Vtb_fetch_top
	./obj_dir/Vtb_fetch_top > sim.log 2>&1; cat sim.log
	grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module tb_fetch_top

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_fetch_top.sv ====
// testbench for the fetch front end
// loads program images, branches into them and walks the expected stream
`timescale 1ns/1ps

module tb_fetch_top;
  import fetch_pkg::*;

  logic              clk;
  logic              rst_n;
  logic              load_we_i;
  logic [RAM_AW-1:0] load_addr_i;
  word_t             load_data_i;
  logic              fetch_req_i;
  logic              branch_i;
  addr_t             branch_addr_i;
  logic              instr_ready_i;
  logic              instr_valid_o;
  word_t             instr_rdata_o;
  addr_t             instr_addr_o;
  logic              busy_o;

  // copy of the ram contents, walked to predict the stream
  word_t img [2**RAM_AW];
  // address of the next instruction the core should see
  addr_t exp_addr;
  logic  busy_seen;
  int    err_count;
  int    check_count;
  int    test_count;
  int    cycle_count = 0;

  fetch_top u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_we_i     (load_we_i),
    .load_addr_i   (load_addr_i),
    .load_data_i   (load_data_i),
    .fetch_req_i   (fetch_req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .instr_ready_i (instr_ready_i),
    .instr_valid_o (instr_valid_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_addr_o  (instr_addr_o),
    .busy_o        (busy_o)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // about 200 instructions at up to 10 cycles each, plus the ram fill, times two
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= 4000) begin
      $display("timeout: the run did not finish within 4000 cycles");
      $display("Done: errors found");
      $finish;
    end
  end

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_flag(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      $display("ERROR time %0t: %s is %b, expected %b", $time, what, got, exp);
      err_count++;
    end
  endtask

  // full compares all 32 bits, otherwise only the compressed low half
  task automatic check_word(input word_t got, input word_t exp, input bit full,
                            input string what);
    check_count++;
    if (full ? (got !== exp) : (got[15:0] !== exp[15:0])) begin
      $display("ERROR time %0t: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      $display("ERROR time %0t: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  ////////////////////
  // drivers
  ////////////////////

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // halfword of the image at a byte address
  function automatic logic [15:0] half_at(input addr_t a);
    word_t w;
    w = img[a[RAM_AW+1:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  task automatic load_word(input int idx, input word_t data);
    load_we_i   = 1'b1;
    load_addr_i = RAM_AW'(idx);
    load_data_i = data;
    img[idx]    = data;
    step();
    load_we_i = 1'b0;
  endtask

  // whole ram, so read-ahead past an image never returns unknowns
  task automatic fill_ram();
    for (int i = 0; i < 2**RAM_AW; i++) begin
      load_word(i, (word_t'(i) * 32'h0101_0101) ^ 32'h5a3c_96e1);
    end
  endtask

  // random halfwords, about half of them open a 32-bit instruction
  task automatic load_mixed(input int base, input int nwords);
    word_t w;
    for (int i = 0; i < nwords; i++) begin
      w = $urandom();
      if ($urandom_range(1, 0) == 1) w[1:0] = 2'b11;
      if ($urandom_range(1, 0) == 1) w[17:16] = 2'b11;
      load_word(base + i, w);
    end
  endtask

  task automatic branch_to(input addr_t target);
    branch_i      = 1'b1;
    branch_addr_i = target;
    exp_addr      = target;
    step();
    branch_i = 1'b0;
  endtask

  // look at the outputs mid-cycle, a transfer happens at the coming edge
  task automatic sample_transfer(output bit took);
    logic [15:0] low_half;
    word_t       exp_word;
    bit          full;
    took = 1'b0;
    @(negedge clk);
    busy_seen = busy_o;
    if (instr_valid_o && instr_ready_i) begin
      low_half = half_at(exp_addr);
      // both low bits set marks a 32-bit instruction
      full     = (low_half[1:0] == 2'b11);
      exp_word = full ? {half_at(exp_addr + 2), low_half} : {16'h0000, low_half};
      check_addr(instr_addr_o, exp_addr, "instruction address");
      check_word(instr_rdata_o, exp_word, full, "instruction data");
      exp_addr = exp_addr + (full ? 4 : 2);
      took     = 1'b1;
    end
    @(posedge clk);
    #1;
  endtask

  // take count instructions within limit cycles
  task automatic consume(input int count, input int limit, input int stall_max);
    int taken;
    int cycles;
    int stall;
    bit took;
    taken  = 0;
    cycles = 0;
    stall  = 0;
    while (taken < count && cycles < limit) begin
      if (stall == 0 && stall_max > 0 && $urandom_range(3, 0) == 0) begin
        stall = $urandom_range(stall_max, 1);
      end
      instr_ready_i = (stall == 0);
      if (stall > 0) stall--;
      sample_transfer(took);
      if (took) taken++;
      cycles++;
    end
    instr_ready_i = 1'b0;
    if (taken < count) begin
      $display("consume: only %0d of %0d instructions arrived within %0d cycles",
               taken, count, limit);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic test_reset();
    int errs;
    errs = err_count;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      check_flag(instr_valid_o, 1'b0, "instr_valid_o before fetch");
      check_flag(busy_o, 1'b0, "busy_o before fetch");
    end
    step();
    report_test("reset", errs);
  endtask

  task automatic test_aligned();
    int errs;
    errs = err_count;
    for (int i = 0; i < 40; i++) begin
      load_word(i, $urandom() | 32'h3);
    end
    fetch_req_i = 1'b1;
    branch_to(32'h0);
    consume(40, 1000, 0);
    report_test("aligned", errs);
  endtask

  task automatic test_mixed();
    int errs;
    errs = err_count;
    load_mixed(64, 48);
    // halfword target inside word 64
    branch_to(32'h102);
    consume(50, 1000, 0);
    report_test("mixed", errs);
  endtask

  task automatic test_backpressure();
    int errs;
    errs = err_count;
    load_mixed(128, 48);
    branch_to(32'h200);
    consume(50, 2000, 12);
    report_test("backpressure", errs);
  endtask

  // second branch lands 0 to 5 cycles after the first one
  task automatic test_redirect();
    int errs;
    bit took;
    errs = err_count;
    for (int k = 0; k < 6; k++) begin
      branch_to(addr_t'(32'h200 + 2 * k));
      // k cycles with ready high, whatever transfers is still checked
      instr_ready_i = 1'b1;
      for (int c = 0; c < k; c++) begin
        sample_transfer(took);
      end
      instr_ready_i = 1'b0;
      branch_to(addr_t'(32'h102 + 4 * k));
      consume(6, 1000, 0);
    end
    report_test("redirect", errs);
  endtask

  task automatic test_idle();
    int errs;
    bit idle;
    bit took;
    errs        = err_count;
    idle        = 1'b0;
    fetch_req_i = 1'b0;
    // drain with ready high, leftovers are still checked against the walk
    for (int i = 0; i < 60 && !idle; i++) begin
      instr_ready_i = 1'b1;
      sample_transfer(took);
      idle = !busy_seen;
    end
    instr_ready_i = 1'b0;
    if (!idle) begin
      $display("idle test: busy_o stayed high after fetching was stopped");
      err_count++;
    end
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check_flag(busy_o, 1'b0, "busy_o while idle");
    end
    step();
    report_test("idle", errs);
  endtask

  initial begin
    void'($urandom(76303));
    err_count     = 0;
    check_count   = 0;
    test_count    = 0;
    rst_n         = 1'b0;
    load_we_i     = 1'b0;
    load_addr_i   = '0;
    load_data_i   = '0;
    fetch_req_i   = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    instr_ready_i = 1'b0;
    exp_addr      = '0;
    busy_seen     = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    fill_ram();
    test_aligned();
    test_mixed();
    test_backpressure();
    test_redirect();
    test_idle();
    $display("tests: %0d  checks: %0d  errors: %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== hdl/fetch_top.sv ====
// fetch front end top level
// prefetch buffer paired with the throttled instruction ram
`timescale 1ns/1ps

module fetch_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         load_we_i,
  input  logic [fetch_pkg::RAM_AW-1:0] load_addr_i,
  input  fetch_pkg::word_t             load_data_i,
  input  logic                         fetch_req_i,
  input  logic                         branch_i,
  input  fetch_pkg::addr_t             branch_addr_i,
  input  logic                         instr_ready_i,
  output logic                         instr_valid_o,
  output fetch_pkg::word_t             instr_rdata_o,
  output fetch_pkg::addr_t             instr_addr_o,
  output logic                         busy_o
);
  import fetch_pkg::*;

  // instruction memory bus
  logic  mem_req;
  logic  mem_gnt;
  addr_t mem_addr;
  word_t mem_rdata;
  logic  mem_rvalid;

  prefetch_buffer u_prefetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (fetch_req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .ready_i       (instr_ready_i),
    .valid_o       (instr_valid_o),
    .rdata_o       (instr_rdata_o),
    .addr_o        (instr_addr_o),
    .mem_req_o     (mem_req),
    .mem_gnt_i     (mem_gnt),
    .mem_addr_o    (mem_addr),
    .mem_rdata_i   (mem_rdata),
    .mem_rvalid_i  (mem_rvalid),
    .busy_o        (busy_o)
  );

  instr_ram u_ram (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i),
    .req_i       (mem_req),
    .gnt_o       (mem_gnt),
    .addr_i      (mem_addr),
    .rdata_o     (mem_rdata),
    .rvalid_o    (mem_rvalid)
  );

endmodule

// ==== hdl/instr_ram.sv ====
// instruction ram, word addressed, loaded before fetching starts
// grant is throttled by an lfsr, read data returns one cycle after grant
`timescale 1ns/1ps

module instr_ram (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        load_we_i,
  input  logic [fetch_pkg::RAM_AW-1:0] load_addr_i,
  input  fetch_pkg::word_t            load_data_i,
  input  logic                        req_i,
  output logic                        gnt_o,
  input  fetch_pkg::addr_t            addr_i,
  output fetch_pkg::word_t            rdata_o,
  output logic                        rvalid_o
);
  import fetch_pkg::*;

  word_t             mem [2**RAM_AW];
  logic [15:0]       lfsr_q;
  logic              lfsr_fb;
  logic [RAM_AW-1:0] rd_index;
  word_t             rdata_q;
  logic              rvalid_q;

  ////////////////////
  // grant throttle
  ////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1, maximal length
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // any nonzero seed
      lfsr_q <= 16'hace1;
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_fb};
    end
  end

  // roughly one cycle in four holds the request off
  assign gnt_o = req_i && (lfsr_q[1:0] != 2'b00);

  ////////////////////
  // storage
  ////////////////////

  // byte address to word index
  assign rd_index = addr_i[RAM_AW+1:2];

  // load port
  always_ff @(posedge clk) begin
    if (load_we_i) begin
      mem[load_addr_i] <= load_data_i;
    end
  end

  // registered read for the granted request
  always_ff @(posedge clk) begin
    if (gnt_o) begin
      rdata_q <= mem[rd_index];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt_o;
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

  // upper address bits would silently wrap onto the array
  a_gnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    gnt_o |-> (addr_i[ADDR_W-1:RAM_AW+2] == '0))
    else $error("instr ram: granted read outside the array");

endmodule

// ==== hdl/prefetch_buffer.sv ====
// prefetch buffer, issues sequential word fetches on req/gnt/rvalid
// and handles branch redirects, feeding the fetch fifo
`timescale 1ns/1ps

module prefetch_buffer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req_i,
  input  logic             branch_i,
  input  fetch_pkg::addr_t branch_addr_i,
  input  logic             ready_i,
  output logic             valid_o,
  output fetch_pkg::word_t rdata_o,
  output fetch_pkg::addr_t addr_o,
  output logic             mem_req_o,
  input  logic             mem_gnt_i,
  output fetch_pkg::addr_t mem_addr_o,
  input  fetch_pkg::word_t mem_rdata_i,
  input  logic             mem_rvalid_i,
  output logic             busy_o
);
  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  // last issued address, tags the word that comes back for it
  addr_t        addr_q;
  addr_t        fetch_addr;
  logic         addr_valid;
  logic         push_valid;
  logic         push_ready;
  logic         fifo_clear;

  // open request or data still owed
  assign busy_o = (state_q != IDLE) || mem_req_o;

  // a branch throws away everything queued
  assign fifo_clear = branch_i;

  // next sequential word
  assign fetch_addr = {addr_q[ADDR_W-1:2], 2'b00} + ADDR_W'(4);

  fetch_fifo u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (fifo_clear),
    .in_addr_i   (addr_q),
    .in_rdata_i  (mem_rdata_i),
    .in_valid_i  (push_valid),
    .in_ready_o  (push_ready),
    .out_valid_o (valid_o),
    .out_ready_i (ready_i),
    .out_rdata_o (rdata_o),
    .out_addr_o  (addr_o)
  );

  ////////////////////
  // fetch fsm
  ////////////////////

  always_comb begin
    state_d    = state_q;
    mem_req_o  = 1'b0;
    mem_addr_o = fetch_addr;
    push_valid = 1'b0;
    addr_valid = 1'b0;
    case (state_q)
      IDLE: begin
        if (branch_i) begin
          mem_addr_o = branch_addr_i;
        end
        // a branch does not wait for room, the fifo is emptied anyway
        if (req_i && (push_ready || branch_i)) begin
          mem_req_o  = 1'b1;
          addr_valid = 1'b1;
          state_d    = mem_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end
      WAIT_GNT: begin
        // hold the request until granted
        mem_req_o  = 1'b1;
        mem_addr_o = addr_q;
        if (branch_i) begin
          mem_addr_o = branch_addr_i;
          addr_valid = 1'b1;
        end
        if (mem_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        if (branch_i) begin
          mem_addr_o = branch_addr_i;
        end
        if (req_i && (push_ready || branch_i)) begin
          if (mem_rvalid_i) begin
            // data in, next request out in the same cycle
            push_valid = 1'b1;
            mem_req_o  = 1'b1;
            addr_valid = 1'b1;
            state_d    = mem_gnt_i ? WAIT_RVALID : WAIT_GNT;
          end else if (branch_i) begin
            // remember the target, the old word is still owed
            addr_valid = 1'b1;
            state_d    = WAIT_ABORTED;
          end
        end else if (mem_rvalid_i) begin
          push_valid = 1'b1;
          state_d    = IDLE;
        end
      end
      WAIT_ABORTED: begin
        mem_addr_o = addr_q;
        if (branch_i) begin
          mem_addr_o = branch_addr_i;
          addr_valid = 1'b1;
        end
        // returning word is dropped, target goes out right away
        if (mem_rvalid_i) begin
          mem_req_o = 1'b1;
          state_d   = mem_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (addr_valid) begin
        addr_q <= mem_addr_o;
      end
    end
  end

  // memory returns data only for a granted request
  a_rvalid_expected: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rvalid_i |-> (state_q inside {WAIT_RVALID, WAIT_ABORTED}))
    else $error("prefetch buffer: rvalid without an outstanding request");

endmodule

// ==== hdl/fetch_fifo.sv ====
// fetch fifo, a short word queue that realigns halfword instructions
// and steps the output address over compressed and full-width code
`timescale 1ns/1ps

module fetch_fifo (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clear_i,
  input  fetch_pkg::addr_t in_addr_i,
  input  fetch_pkg::word_t in_rdata_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output fetch_pkg::word_t out_rdata_o,
  output fetch_pkg::addr_t out_addr_o
);
  import fetch_pkg::*;

  // entry 0 is the head, seen at the output
  addr_t                 addr_q    [FIFO_DEPTH];
  addr_t                 addr_int  [FIFO_DEPTH];
  addr_t                 addr_n    [FIFO_DEPTH];
  word_t                 rdata_q   [FIFO_DEPTH];
  word_t                 rdata_int [FIFO_DEPTH];
  word_t                 rdata_n   [FIFO_DEPTH];
  logic [FIFO_DEPTH-1:0] valid_q;
  logic [FIFO_DEPTH-1:0] valid_int;
  logic [FIFO_DEPTH-1:0] valid_n;

  word_t head_rdata;
  word_t next_rdata;
  logic  head_valid;
  logic  next_valid;
  logic  aligned_is_compressed;
  logic  unaligned_is_compressed;
  logic  instr_valid;
  logic  transfer;
  addr_t addr_next;

  ////////////////////
  // output side
  ////////////////////

  // an empty head is bypassed by the word arriving now
  assign head_rdata = valid_q[0] ? rdata_q[0] : in_rdata_i;
  assign head_valid = valid_q[0] | in_valid_i;
  // second word, either stored or arriving behind a stored head
  assign next_rdata = valid_q[1] ? rdata_q[1] : in_rdata_i;
  assign next_valid = valid_q[1] | (valid_q[0] & in_valid_i);

  assign out_addr_o = valid_q[0] ? addr_q[0] : in_addr_i;

  assign aligned_is_compressed   = head_rdata[1:0] != 2'b11;
  assign unaligned_is_compressed = head_rdata[17:16] != 2'b11;

  // halfword aligner
  always_comb begin
    if (out_addr_o[1]) begin
      // upper half of head, then lower half of the next word
      out_rdata_o = {next_rdata[15:0], head_rdata[31:16]};
      // a straddling 32-bit instruction needs both words
      instr_valid = unaligned_is_compressed ? head_valid : next_valid;
    end else begin
      out_rdata_o = head_rdata;
      instr_valid = head_valid;
    end
  end

  // nothing leaves while the stream is being redirected
  assign out_valid_o = instr_valid & ~clear_i;
  assign transfer    = out_valid_o & out_ready_i;

  ////////////////////
  // input side
  ////////////////////

  // one slot stays free for the word of the request already in flight
  assign in_ready_o = ~valid_q[FIFO_DEPTH-2];

  // write the incoming word into the lowest free entry
  always_comb begin : push_slot
    logic placed;
    placed    = 1'b0;
    addr_int  = addr_q;
    rdata_int = rdata_q;
    valid_int = valid_q;
    if (in_valid_i) begin
      for (int i = 0; i < FIFO_DEPTH; i++) begin
        if (!valid_q[i] && !placed) begin
          addr_int[i]  = in_addr_i;
          rdata_int[i] = in_rdata_i;
          valid_int[i] = 1'b1;
          placed       = 1'b1;
        end
      end
    end
  end

  ////////////////////
  // queue stepping
  ////////////////////

  // first byte of the word after the head
  assign addr_next = {out_addr_o[ADDR_W-1:2], 2'b00} + ADDR_W'(4);

  always_comb begin
    addr_n  = addr_int;
    rdata_n = rdata_int;
    valid_n = valid_int;
    if (transfer) begin
      if (!out_addr_o[1] && aligned_is_compressed) begin
        // low half consumed, upper half of the same word is next
        addr_n[0] = {out_addr_o[ADDR_W-1:2], 2'b10};
      end else begin
        for (int i = 0; i < FIFO_DEPTH-1; i++) begin
          addr_n[i]  = addr_int[i+1];
          rdata_n[i] = rdata_int[i+1];
          valid_n[i] = valid_int[i+1];
        end
        valid_n[FIFO_DEPTH-1] = 1'b0;
        // straddling instruction also ate the low half of the next word
        if (out_addr_o[1] && !unaligned_is_compressed) begin
          addr_n[0] = {addr_next[ADDR_W-1:2], 2'b10};
        end else begin
          addr_n[0] = addr_next;
        end
      end
    end
  end

  // entry valid flags, cleared outright on a redirect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (clear_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_n;
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    addr_q  <= addr_n;
    rdata_q <= rdata_n;
  end

  // prefetch flow control must never push into a full queue
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid_i |-> (!valid_q[FIFO_DEPTH-1] || clear_i))
    else $error("fetch fifo: push while last entry is full");

endmodule

// ==== hdl/fetch_pkg.sv ====
// fetch front end shared definitions
// bus widths, fifo depth, ram size, word types and fetch states
package fetch_pkg;

  ////////////////////
  // widths and sizes
  ////////////////////

  // byte address width on the fetch side
  localparam int ADDR_W     = 32;
  // one memory word, also the width of an instruction leaving the fifo
  localparam int DATA_W     = 32;
  // word entries in the fetch fifo, at least 3 so an in-flight word has a slot
  localparam int FIFO_DEPTH = 3;
  // ram word index width, 256 words
  localparam int RAM_AW     = 8;

  ////////////////////
  // types
  ////////////////////

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;

  // request/grant/rvalid tracking in the prefetch buffer
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED
  } fetch_state_e;

endpackage
